//--- udp_tx_consts.svh
`ifndef UDP_TX_CONSTS_SVH
`define UDP_TX_CONSTS_SVH

// Payload byte count and FIFO size.
`define PAYLOAD_WIDTH 11
`define FIFO_DEPTH    2048

// Field lengths in bytes, one byte per GMII cycle.
`define PREAMBLE_BYTES 7
`define SFD_BYTES      1
`define HEADER_BYTES   42
`define FCS_BYTES      4
`define GAP_BYTES      12

`define PREAMBLE_VAL 8'h55
`define SFD_VAL      8'hD5

// Fixed Ethernet and IPv4 header fields.
`define ETHERTYPE_IPV4 16'h0800
`define IP_VER_IHL     8'h45
`define IP_TOS         8'h00
`define IP_ID          16'h0000
`define IP_FLAGS_FRAG  16'h4000 // Don't fragment.
`define IP_TTL         8'd64
`define IP_PROTO_UDP   8'd17

`endif

//--- udp_tx_pkg.sv
`default_nettype none

package udp_tx_pkg;

    // Sequencer states, in the order the fields go out.
    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        HEADER,
        DATA,
        FCS,
        GAP
    } frame_state_t;

    // Last wire field first, so the first wire byte sits in bits [7:0].
    // Multi-byte fields therefore hold their bytes swapped.
    typedef struct packed {
        logic [15:0] udp_checksum;
        logic [15:0] udp_length;
        logic [15:0] dst_port;
        logic [15:0] src_port;
        logic [31:0] dst_ip;
        logic [31:0] src_ip;
        logic [15:0] ip_checksum;
        logic [7:0]  protocol;
        logic [7:0]  ttl;
        logic [15:0] flags_frag;
        logic [15:0] ip_id;
        logic [15:0] total_length;
        logic [7:0]  tos;
        logic [7:0]  ver_ihl;
        logic [15:0] ethertype;
        logic [47:0] src_mac;
        logic [47:0] dst_mac;
    } ethernet_header_t;

endpackage

`default_nettype wire

//--- byte_stream_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_tx_consts.svh"

interface byte_stream_if;
    logic [7:0]              tdata;
    logic                    tvalid;
    logic                    tready;
    logic [`PAYLOAD_WIDTH:0] level;  // Bytes held in the FIFO.

    modport source (
        output tdata,
        output tvalid,
        output level,
        input  tready
    );

    modport sink (
        input  tdata,
        input  tvalid,
        input  level,
        output tready
    );
endinterface

`default_nettype wire

//--- byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_tx_consts.svh"

module byte_fifo (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic [7:0]    wr_data_i,
    input  logic          wr_valid_i,
    output logic          wr_ready_o,
    byte_stream_if.source m_stream
);

    localparam int ADDR_WIDTH = $clog2(`FIFO_DEPTH);
    localparam logic [`PAYLOAD_WIDTH:0] FULL_COUNT = `FIFO_DEPTH;

    logic [7:0]              mem [`FIFO_DEPTH];
    logic [ADDR_WIDTH-1:0]   wr_ptr;
    logic [ADDR_WIDTH-1:0]   rd_ptr;
    logic [`PAYLOAD_WIDTH:0] count;
    logic                    wr_en;
    logic                    rd_en;

    assign wr_ready_o = (count != FULL_COUNT);
    assign wr_en      = wr_valid_i && wr_ready_o;
    assign rd_en      = m_stream.tvalid && m_stream.tready;

    // First word fall through.
    assign m_stream.tdata  = mem[rd_ptr];
    assign m_stream.tvalid = (count != '0);
    assign m_stream.level  = count;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // Depth is a power of two so the pointers wrap on their own.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count; // Idle or write and pop together.
            endcase
        end
    end

endmodule

`default_nettype wire

//--- eth_header_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_tx_consts.svh"

module eth_header_gen (
    input  logic                         clk_i,
    input  logic [47:0]                  src_mac_i,
    input  logic [31:0]                  src_ip_i,
    input  logic [15:0]                  src_port_i,
    input  logic [47:0]                  dst_mac_i,
    input  logic [31:0]                  dst_ip_i,
    input  logic [15:0]                  dst_port_i,
    input  logic [`PAYLOAD_WIDTH-1:0]    payload_bytes_i,
    output udp_tx_pkg::ethernet_header_t header_o
);
    import udp_tx_pkg::*;

    ethernet_header_t hdr;
    logic [15:0]      ip_total_len;
    logic [15:0]      udp_len;
    logic [19:0]      csum_sum;
    logic [16:0]      csum_fold;
    logic [15:0]      csum;

    assign ip_total_len = 16'd28 + 16'(payload_bytes_i); // IP + UDP headers.
    assign udp_len      = 16'd8 + 16'(payload_bytes_i);

    // Checksum field counts as zero.
    assign csum_sum = 20'({`IP_VER_IHL, `IP_TOS})
                    + 20'(ip_total_len)
                    + 20'(`IP_ID)
                    + 20'(`IP_FLAGS_FRAG)
                    + 20'({`IP_TTL, `IP_PROTO_UDP})
                    + 20'(src_ip_i[31:16])
                    + 20'(src_ip_i[15:0])
                    + 20'(dst_ip_i[31:16])
                    + 20'(dst_ip_i[15:0]);

    // End-around carry, twice covers the worst case.
    assign csum_fold = 17'(csum_sum[15:0]) + 17'(csum_sum[19:16]);
    assign csum      = ~(csum_fold[15:0] + 16'(csum_fold[16]));

    always_comb begin
        hdr.dst_mac      = {<<8{dst_mac_i}};
        hdr.src_mac      = {<<8{src_mac_i}};
        hdr.ethertype    = {<<8{`ETHERTYPE_IPV4}};
        hdr.ver_ihl      = `IP_VER_IHL;
        hdr.tos          = `IP_TOS;
        hdr.total_length = {<<8{ip_total_len}};
        hdr.ip_id        = {<<8{`IP_ID}};
        hdr.flags_frag   = {<<8{`IP_FLAGS_FRAG}};
        hdr.ttl          = `IP_TTL;
        hdr.protocol     = `IP_PROTO_UDP;
        hdr.ip_checksum  = {<<8{csum}};
        hdr.src_ip       = {<<8{src_ip_i}};
        hdr.dst_ip       = {<<8{dst_ip_i}};
        hdr.src_port     = {<<8{src_port_i}};
        hdr.dst_port     = {<<8{dst_port_i}};
        hdr.udp_length   = {<<8{udp_len}};
        hdr.udp_checksum = 16'h0000; // Not computed, allowed for IPv4.
    end

    always_ff @(posedge clk_i) begin
        header_o <= hdr;
    end

endmodule

`default_nettype wire

//--- crc32_gen.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_gen (
    input  logic        clk_i,
    input  logic        clear_i,
    input  logic        en_i,
    input  logic [7:0]  data_i,
    output logic [31:0] crc_o
);

    localparam logic [31:0] POLY = 32'hEDB88320; // Reflected.

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // One byte, least significant bit first.
    always_comb begin
        crc_next = crc_q ^ {24'h000000, data_i};
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (clear_i) begin
            crc_q <= '1;
        end else if (en_i) begin
            crc_q <= crc_next;
        end
    end

    // Includes the byte currently presented.
    assign crc_o = en_i ? ~crc_next : ~crc_q;

endmodule

`default_nettype wire

//--- packet_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_tx_consts.svh"

module packet_gen (
    input  logic                      clk_i,
    input  logic                      rst_i,
    byte_stream_if.sink               s_stream,
    input  logic [`PAYLOAD_WIDTH-1:0] payload_bytes_i,
    input  logic [47:0]               src_mac_i,
    input  logic [31:0]               src_ip_i,
    input  logic [15:0]               src_port_i,
    input  logic [47:0]               dst_mac_i,
    input  logic [31:0]               dst_ip_i,
    input  logic [15:0]               dst_port_i,
    output logic                      tx_en_o,
    output logic [7:0]                tx_d_o
);
    import udp_tx_pkg::*;

    frame_state_t                 state;
    frame_state_t                 next_state;
    logic [`PAYLOAD_WIDTH-1:0]    state_cnt;
    ethernet_header_t             header;
    logic [`HEADER_BYTES*8-1:0]   header_buf;
    logic [`PREAMBLE_BYTES*8-1:0] preamble_buf;
    logic [`SFD_BYTES*8-1:0]      sfd_buf;
    logic [`FCS_BYTES*8-1:0]      fcs_buf;
    logic [31:0]                  crc;
    logic [7:0]                   data_buf;
    logic                         data_valid;
    logic [7:0]                   tx_data;
    logic                         tx_valid;

    eth_header_gen i_eth_header_gen (
        .clk_i          (clk_i),
        .src_mac_i      (src_mac_i),
        .src_ip_i       (src_ip_i),
        .src_port_i     (src_port_i),
        .dst_mac_i      (dst_mac_i),
        .dst_ip_i       (dst_ip_i),
        .dst_port_i     (dst_port_i),
        .payload_bytes_i(payload_bytes_i),
        .header_o       (header)
    );

    crc32_gen i_crc32_gen (
        .clk_i  (clk_i),
        .clear_i(state == IDLE),
        .en_i   ((state == HEADER) || (state == DATA)),
        .data_i (tx_data),
        .crc_o  (crc)
    );

    always_comb begin
        next_state = state;
        case (state)
            IDLE: if ((s_stream.level >= payload_bytes_i) && (payload_bytes_i != '0)) begin
                next_state = PREAMBLE; // Whole payload buffered.
            end
            PREAMBLE: if (state_cnt == `PREAMBLE_BYTES - 1) next_state = SFD;
            SFD: if (state_cnt == `SFD_BYTES - 1) next_state = HEADER;
            HEADER: if (state_cnt == `HEADER_BYTES - 1) next_state = DATA;
            DATA: if (state_cnt == payload_bytes_i - 1'b1) next_state = FCS;
            FCS: if (state_cnt == `FCS_BYTES - 1) next_state = GAP;
            GAP: if (state_cnt == `GAP_BYTES - 1) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state     <= IDLE;
            state_cnt <= '0;
        end else begin
            state     <= next_state;
            state_cnt <= (state != next_state) ? '0 : state_cnt + 1'b1;
        end
    end

    // Pop one byte per DATA cycle, one cycle ahead of the wire.
    assign s_stream.tready = (next_state == DATA);

    always_comb begin
        tx_valid = 1'b0;
        tx_data  = 8'h00;
        case (state)
            PREAMBLE: begin
                tx_valid = 1'b1;
                tx_data  = preamble_buf[7:0];
            end
            SFD: begin
                tx_valid = 1'b1;
                tx_data  = sfd_buf[7:0];
            end
            HEADER: begin
                tx_valid = 1'b1;
                tx_data  = header_buf[7:0];
            end
            DATA: begin
                tx_valid = data_valid;
                tx_data  = data_buf;
            end
            FCS: begin
                tx_valid = 1'b1;
                tx_data  = fcs_buf[7:0];
            end
            default: tx_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (state == IDLE) begin
            header_buf   <= header;
            preamble_buf <= {`PREAMBLE_BYTES{`PREAMBLE_VAL}};
            sfd_buf      <= {`SFD_BYTES{`SFD_VAL}};
        end
        if (state == PREAMBLE) preamble_buf <= preamble_buf >> 8;
        if (state == SFD) sfd_buf <= sfd_buf >> 8;
        if (state == HEADER) header_buf <= header_buf >> 8;
        if ((next_state == FCS) && (state != FCS)) begin
            fcs_buf <= crc; // Already holds the last payload byte.
        end else if (state == FCS) begin
            fcs_buf <= fcs_buf >> 8;
        end
        if (s_stream.tready) data_buf <= s_stream.tdata;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            data_valid <= 1'b0;
            tx_en_o    <= 1'b0;
        end else begin
            if (s_stream.tready) data_valid <= s_stream.tvalid;
            tx_en_o <= tx_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        tx_d_o <= tx_data;
    end

endmodule

`default_nettype wire

//--- udp_tx_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_tx_consts.svh"

module udp_tx_top (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic [7:0]                s_tdata_i,
    input  logic                      s_tvalid_i,
    output logic                      s_tready_o,
    input  logic [`PAYLOAD_WIDTH-1:0] payload_bytes_i,
    input  logic [47:0]               src_mac_i,
    input  logic [31:0]               src_ip_i,
    input  logic [15:0]               src_port_i,
    input  logic [47:0]               dst_mac_i,
    input  logic [31:0]               dst_ip_i,
    input  logic [15:0]               dst_port_i,
    output logic                      gmii_tx_en_o,
    output logic [7:0]                gmii_txd_o
);

    byte_stream_if payload_stream ();

    byte_fifo i_byte_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_data_i (s_tdata_i),
        .wr_valid_i(s_tvalid_i),
        .wr_ready_o(s_tready_o),
        .m_stream  (payload_stream)
    );

    packet_gen i_packet_gen (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .s_stream       (payload_stream),
        .payload_bytes_i(payload_bytes_i),
        .src_mac_i      (src_mac_i),
        .src_ip_i       (src_ip_i),
        .src_port_i     (src_port_i),
        .dst_mac_i      (dst_mac_i),
        .dst_ip_i       (dst_ip_i),
        .dst_port_i     (dst_port_i),
        .tx_en_o        (gmii_tx_en_o),
        .tx_d_o         (gmii_txd_o)
    );

endmodule

`default_nettype wire

//--- tb_udp_tx_assertions.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_tx_consts.svh"

module tb_udp_tx_assertions (
    input logic                      clk_i,
    input logic                      rst_i,
    input logic                      tx_en_i,
    input logic                      tready_i,
    input logic                      tvalid_i,
    input udp_tx_pkg::frame_state_t  state_i
);
    import udp_tx_pkg::*;

    localparam int MAX_RUN = 54 + `FIFO_DEPTH;

    int run_cnt;

    always_ff @(posedge clk_i) begin
        if (rst_i || !tx_en_i) begin
            run_cnt <= 0;
        end else begin
            run_cnt <= run_cnt + 1;
        end
    end

    tx_quiet_in_reset: assert property (@(posedge clk_i) rst_i |=> !tx_en_i)
        else $error("GMII transmit enable is high during or just after reset");

    // Ready leads the wire by one cycle, so it starts in the last header cycle.
    // Every pop must find a buffered byte.
    ready_only_for_data: assert property (@(posedge clk_i) disable iff (rst_i)
        tready_i |-> tvalid_i && ((state_i == DATA) || (state_i == HEADER)))
        else $error("FIFO ready is high outside the payload phase or with the FIFO empty");

    run_not_too_long: assert property (@(posedge clk_i) disable iff (rst_i)
        run_cnt <= MAX_RUN)
        else $error("GMII transmit enable run is longer than the largest frame");

endmodule

bind packet_gen tb_udp_tx_assertions i_assertions (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .tx_en_i (tx_en_o),
    .tready_i(s_stream.tready),
    .tvalid_i(s_stream.tvalid),
    .state_i (state)
);

`default_nettype wire

//--- tb_udp_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_tx_consts.svh"

module tb_udp_tx;

    localparam int NUM_FRAMES = 8;
    localparam int MAX_LEN    = 300;

    logic                      clk_i = 1'b0;
    logic                      rst_i;
    logic [7:0]                s_tdata_i;
    logic                      s_tvalid_i;
    logic                      s_tready_o;
    logic [`PAYLOAD_WIDTH-1:0] payload_bytes_i;
    logic [47:0]               src_mac_i;
    logic [31:0]               src_ip_i;
    logic [15:0]               src_port_i;
    logic [47:0]               dst_mac_i;
    logic [31:0]               dst_ip_i;
    logic [15:0]               dst_port_i;
    logic                      gmii_tx_en_o;
    logic [7:0]                gmii_txd_o;

    logic [7:0]  payload [NUM_FRAMES][MAX_LEN];
    int          frame_len [NUM_FRAMES];
    logic [47:0] f_src_mac [NUM_FRAMES];
    logic [47:0] f_dst_mac [NUM_FRAMES];
    logic [31:0] f_src_ip [NUM_FRAMES];
    logic [31:0] f_dst_ip [NUM_FRAMES];
    logic [15:0] f_src_port [NUM_FRAMES];
    logic [15:0] f_dst_port [NUM_FRAMES];
    logic [7:0]  exp_q [$];
    logic [31:0] lfsr = 32'h5d15;
    int          frames_done = 0;
    int          mismatch_cnt = 0;
    int          other_cnt = 0;
    logic        params_ready = 1'b0;

    udp_tx_top i_dut (.*);

    always #50 clk_i = ~clk_i;

    // Galois LFSR, one step per bit.
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ 32'h80200003;
            v = {v[62:0], b};
        end
        return v;
    endfunction

    function automatic void push_be(input logic [47:0] v, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) exp_q.push_back(v[i*8 +: 8]);
    endfunction

    // Expected wire bytes of frame k, preamble through FCS.
    function automatic void build_expected(input int k);
        logic [31:0] sum;
        logic [31:0] crc;
        logic [15:0] csum;
        int          n;
        n = frame_len[k];
        exp_q.delete();
        repeat (7) exp_q.push_back(8'h55);
        exp_q.push_back(8'hD5);
        push_be(f_dst_mac[k], 6);
        push_be(f_src_mac[k], 6);
        push_be(48'h0800, 2);
        push_be(48'h4500, 2);
        push_be(48'(28 + n), 2);
        push_be(48'h0000, 2);
        push_be(48'h4000, 2);
        push_be(48'h4011, 2);
        push_be(48'h0000, 2); // Checksum, filled in below.
        push_be(48'(f_src_ip[k]), 4);
        push_be(48'(f_dst_ip[k]), 4);
        push_be(48'(f_src_port[k]), 2);
        push_be(48'(f_dst_port[k]), 2);
        push_be(48'(8 + n), 2);
        push_be(48'h0000, 2);
        for (int i = 0; i < n; i++) exp_q.push_back(payload[k][i]);
        sum = 0;
        for (int i = 0; i < 20; i += 2) sum = sum + {16'h0, exp_q[22+i], exp_q[23+i]};
        while (sum[31:16] != 0) sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        csum = ~sum[15:0];
        exp_q[32] = csum[15:8];
        exp_q[33] = csum[7:0];
        crc = '1;
        for (int i = 8; i < exp_q.size(); i++) begin
            crc = crc ^ {24'h0, exp_q[i]};
            for (int j = 0; j < 8; j++) crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) exp_q.push_back(crc[i*8 +: 8]);
    endfunction

    // Entered and left just after a rising edge.
    task automatic send_byte(input logic [7:0] b, input int gap, input logic check_idle);
        repeat (gap) begin
            s_tvalid_i <= 1'b0;
            @(posedge clk_i);
            if (check_idle) assert (!gmii_tx_en_o) else begin
                other_cnt++;
                $display("Frame started before its payload was complete");
            end
        end
        s_tdata_i  <= b;
        s_tvalid_i <= 1'b1;
        @(posedge clk_i);
        while (!s_tready_o) @(posedge clk_i);
        if (check_idle) assert (!gmii_tx_en_o) else begin
            other_cnt++;
            $display("Frame started before its payload was complete");
        end
    endtask

    initial begin : capture
        int   pos;
        int   low_cnt;
        logic in_frame;
        pos = 0;
        low_cnt = 0;
        in_frame = 1'b0;
        forever begin
            @(posedge clk_i);
            if (gmii_tx_en_o) begin
                if (!in_frame) begin
                    in_frame = 1'b1;
                    pos = 0;
                    assert (frames_done < NUM_FRAMES) else begin
                        other_cnt++;
                        $display("Unexpected frame after the last expected one");
                    end
                    if (frames_done > 0) assert (low_cnt >= `GAP_BYTES) else begin
                        other_cnt++;
                        $display("Inter-frame gap of only %0d cycles", low_cnt);
                    end
                    if (frames_done < NUM_FRAMES) build_expected(frames_done);
                end
                assert (pos < exp_q.size()) else begin
                    other_cnt++;
                    $display("Frame %0d is longer than expected", frames_done);
                end
                if (pos < exp_q.size()) assert (gmii_txd_o == exp_q[pos]) else begin
                    mismatch_cnt++;
                    $display("Mismatch gmii_txd_o frame %0d byte %0d: got %h expected %h",
                             frames_done, pos, gmii_txd_o, exp_q[pos]);
                end
                pos++;
            end else begin
                if (in_frame) begin
                    in_frame = 1'b0;
                    assert (pos == exp_q.size()) else begin
                        mismatch_cnt++;
                        $display("Mismatch gmii_tx_en_o run length: got %h expected %h",
                                 pos, exp_q.size());
                    end
                    frames_done++;
                    low_cnt = 0;
                end
                low_cnt++;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (params_ready);
        limit = 200;
        for (int k = 0; k < NUM_FRAMES; k++) limit += 6 * frame_len[k] + 54 + 20;
        repeat (limit) @(posedge clk_i);
        $display("Timeout after %0d cycles with %0d frames received", limit, frames_done);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : stimulus
        rst_i = 1'b1;
        s_tdata_i = 8'h00;
        s_tvalid_i = 1'b0;
        payload_bytes_i = '0;
        src_mac_i = '0;
        src_ip_i = '0;
        src_port_i = '0;
        dst_mac_i = '0;
        dst_ip_i = '0;
        dst_port_i = '0;
        for (int k = 0; k < NUM_FRAMES; k++) begin
            frame_len[k]  = (k == 0) ? 8 : 1 + int'(rand_bits(9) % MAX_LEN);
            f_src_mac[k]  = (k == 0) ? 48'h02_00_00_00_00_01 : 48'(rand_bits(48));
            f_dst_mac[k]  = (k == 0) ? 48'hFF_FF_FF_FF_FF_FF : 48'(rand_bits(48));
            f_src_ip[k]   = (k == 0) ? 32'hC0A8_0001 : 32'(rand_bits(32));
            f_dst_ip[k]   = (k == 0) ? 32'hC0A8_0002 : 32'(rand_bits(32));
            f_src_port[k] = (k == 0) ? 16'd1234 : 16'(rand_bits(16));
            f_dst_port[k] = (k == 0) ? 16'd5678 : 16'(rand_bits(16));
            if (k == NUM_FRAMES - 1) begin // Shares the header of the frame before it.
                frame_len[k]  = frame_len[k-1];
                f_src_mac[k]  = f_src_mac[k-1];
                f_dst_mac[k]  = f_dst_mac[k-1];
                f_src_ip[k]   = f_src_ip[k-1];
                f_dst_ip[k]   = f_dst_ip[k-1];
                f_src_port[k] = f_src_port[k-1];
                f_dst_port[k] = f_dst_port[k-1];
            end
            for (int i = 0; i < frame_len[k]; i++) begin
                payload[k][i] = (k == 0) ? 8'(8'hA0 + i) : 8'(rand_bits(8));
            end
        end
        params_ready = 1'b1;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        @(posedge clk_i);
        assert (!gmii_tx_en_o && s_tready_o) else begin
            other_cnt++;
            $display("Wrong idle outputs after reset");
        end
        for (int k = 0; k < NUM_FRAMES; k++) begin
            if (k != NUM_FRAMES - 1) begin
                s_tvalid_i <= 1'b0;
                while (frames_done < k) @(posedge clk_i);
            end
            payload_bytes_i <= frame_len[k][`PAYLOAD_WIDTH-1:0];
            src_mac_i  <= f_src_mac[k];
            dst_mac_i  <= f_dst_mac[k];
            src_ip_i   <= f_src_ip[k];
            dst_ip_i   <= f_dst_ip[k];
            src_port_i <= f_src_port[k];
            dst_port_i <= f_dst_port[k];
            for (int i = 0; i < frame_len[k]; i++) begin
                // Last payload streams without gaps while the frame ahead is sent.
                send_byte(payload[k][i], (k == NUM_FRAMES - 1) ? 0 : int'(rand_bits(2)),
                          k != NUM_FRAMES - 1);
            end
        end
        s_tvalid_i <= 1'b0;
        while (frames_done < NUM_FRAMES) @(posedge clk_i);
        repeat (40) @(posedge clk_i);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
udp_tx_pkg.sv
byte_stream_if.sv
byte_fifo.sv
eth_header_gen.sv
crc32_gen.sv
packet_gen.sv
udp_tx_top.sv
tb_udp_tx_assertions.sv
tb_udp_tx.sv

//--- run_sim.sh
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_udp_tx \
    -o sim_udp_tx > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_udp_tx > sim.log 2>&1 || true

grep -qx "Simulation finished: PASS" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }
